/* source/fetch_params.svh */
// Fetch stage constants: widths, start address, no-op word and fetch step

`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// Data and address width
`define FETCH_XLEN 32

// Address loaded by reset_n and by sys_reset, must be word aligned
`define FETCH_START_ADDR 32'h0000_0000

// addi x0, x0, 0
`define FETCH_NOP 32'h0000_0013

// Bytes per sequential fetch
`define FETCH_STEP 32'd4

`endif

/* source/fetch_pkg.sv */
// Fetch stage types: byte and word addresses, instruction word, jump reason
`default_nettype none

`include "fetch_params.svh"

package fetch_pkg;

    // Byte address
    typedef logic [`FETCH_XLEN-1:0] addr_t;

    // Word index, the byte address without its two low bits
    typedef logic [`FETCH_XLEN-3:0] word_addr_t;

    typedef logic [`FETCH_XLEN-1:0] instr_t;

    // Why the last redirect happened, one-hot
    typedef enum logic [2:0] {
        NO_JMP = 3'b001,
        CTX_SW = 3'b010,
        JMP_XU = 3'b100
    } jmp_reason_t;

endpackage

`default_nettype wire

/* source/redirect_if.sv */
// Redirect request bundle: execute jump and context switch with targets
`timescale 1ns/1ps
`default_nettype none

interface redirect_if;

    // Single-cycle pulses, no acknowledge
    logic              jump;
    fetch_pkg::addr_t  jump_target;
    logic              ctx_switch;
    fetch_pkg::addr_t  ctx_switch_target;

    // Driver side
    modport source (
        output jump,
        output jump_target,
        output ctx_switch,
        output ctx_switch_target
    );

    // Consumer side, address and PC control
    modport sink (
        input jump,
        input jump_target,
        input ctx_switch,
        input ctx_switch_target
    );

endinterface

`default_nettype wire

/* source/iaddr_control.sv */
// Instruction address control: next-address select, address register, jump flags
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module iaddr_control (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              sys_reset,
    input  logic              enable_i,
    redirect_if.sink          redir,
    output fetch_pkg::addr_t  instruction_address_o,
    output logic              jumping_o,
    output logic              jumped_r_o,
    output logic              jumped_r2_o
);

    localparam fetch_pkg::addr_t START_ADDR = `FETCH_START_ADDR;

    logic                  jumped;
    fetch_pkg::word_addr_t iaddr_r;
    fetch_pkg::word_addr_t iaddr_advance;
    fetch_pkg::word_addr_t iaddr_target;

    //////////////////////////////////////////////////
    // Next address
    //////////////////////////////////////////////////

    assign jumped        = redir.ctx_switch || redir.jump;
    assign iaddr_advance = iaddr_r + 1'b1;

    // Context switch wins over an execute jump in the same cycle
    always_comb begin
        if (redir.ctx_switch)
            iaddr_target = redir.ctx_switch_target[`FETCH_XLEN-1:2];
        else if (redir.jump)
            iaddr_target = redir.jump_target[`FETCH_XLEN-1:2];
        else
            iaddr_target = iaddr_advance;
    end

    // Redirects load even while stalled
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            iaddr_r <= START_ADDR[`FETCH_XLEN-1:2];
        end else if (sys_reset) begin
            iaddr_r <= START_ADDR[`FETCH_XLEN-1:2];
        end else if (jumped || enable_i) begin
            iaddr_r <= iaddr_target;
        end
    end

    assign instruction_address_o = {iaddr_r, 2'b00};

    //////////////////////////////////////////////////
    // Jump flags
    //////////////////////////////////////////////////

    // Set by a redirect, cleared by the next enabled edge
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            jumped_r_o <= 1'b1;
        end else if (sys_reset) begin
            jumped_r_o <= 1'b1;
        end else if (jumped) begin
            jumped_r_o <= 1'b1;
        end else if (enable_i) begin
            jumped_r_o <= 1'b0;
        end
    end

    // One enabled edge later, selects the jump target for the PC
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            jumped_r2_o <= 1'b1;
        end else if (sys_reset) begin
            jumped_r2_o <= 1'b1;
        end else if (enable_i) begin
            jumped_r2_o <= jumped_r_o;
        end
    end

    // Bubble marker, spans the redirect and the word fetched from the target
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            jumping_o <= 1'b1;
        end else if (sys_reset) begin
            jumping_o <= 1'b1;
        end else if (jumped || jumped_r_o) begin
            jumping_o <= 1'b1;
        end else if (enable_i) begin
            jumping_o <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* source/pc_control.sv */
// PC control: jump reason, target registers and PC of the fetched instruction
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module pc_control (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              sys_reset,
    input  logic              enable_i,
    redirect_if.sink          redir,
    input  logic              jumped_r_i,
    input  logic              jumped_r2_i,
    output fetch_pkg::addr_t  pc_o
);

    fetch_pkg::jmp_reason_t jmp_reason_r;
    fetch_pkg::addr_t       jump_target_r;
    fetch_pkg::addr_t       ctx_switch_target_r;
    fetch_pkg::addr_t       pc_jumped;
    fetch_pkg::addr_t       pc_jumped_r;
    fetch_pkg::addr_t       pc_update;

    //////////////////////////////////////////////////
    // Redirect capture
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            jmp_reason_r <= fetch_pkg::NO_JMP;
        end else if (sys_reset) begin
            jmp_reason_r <= fetch_pkg::NO_JMP;
        end else if (redir.ctx_switch) begin
            jmp_reason_r <= fetch_pkg::CTX_SW;
        end else if (redir.jump) begin
            jmp_reason_r <= fetch_pkg::JMP_XU;
        end else begin
            jmp_reason_r <= fetch_pkg::NO_JMP;
        end
    end

    // Targets sampled every cycle, only read one cycle after a request
    always_ff @(posedge clk) begin
        jump_target_r       <= redir.jump_target;
        ctx_switch_target_r <= redir.ctx_switch_target;
    end

    always_comb begin
        unique case (jmp_reason_r)
            fetch_pkg::CTX_SW: pc_jumped = ctx_switch_target_r;
            default:           pc_jumped = jump_target_r;
        endcase
    end

    // Holds the target over a stalled bubble, reset value seeds the first PC
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc_jumped_r <= `FETCH_START_ADDR;
        end else if (sys_reset) begin
            pc_jumped_r <= `FETCH_START_ADDR;
        end else if (jumped_r_i && (jmp_reason_r != fetch_pkg::NO_JMP)) begin
            pc_jumped_r <= pc_jumped;
        end
    end

    //////////////////////////////////////////////////
    // PC of the fetched instruction
    //////////////////////////////////////////////////

    assign pc_update = jumped_r2_i ? pc_jumped_r : pc_o + `FETCH_STEP;

    // Soft reset leaves the PC alone
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc_o <= '0;
        end else if (enable_i) begin
            pc_o <= pc_update;
        end
    end

endmodule

`default_nettype wire

/* source/instr_buffer.sv */
// Instruction data control: stall hold register and instruction output register
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module instr_buffer (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               sys_reset,
    input  logic               enable_i,
    input  fetch_pkg::instr_t  instruction_data_i,
    output fetch_pkg::instr_t  instruction_o
);

    logic              enable_r;
    fetch_pkg::instr_t idata_held;
    fetch_pkg::instr_t instruction_fetched;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            enable_r <= 1'b0;
        end else begin
            enable_r <= enable_i;
        end
    end

    // Memory word that arrived just as the stall began
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            idata_held <= `FETCH_NOP;
        end else if (!enable_i && enable_r) begin
            idata_held <= instruction_data_i;
        end
    end

    // First edge after a stall takes the saved word
    assign instruction_fetched = enable_r ? instruction_data_i : idata_held;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            instruction_o <= `FETCH_NOP;
        end else if (sys_reset) begin
            instruction_o <= `FETCH_NOP;
        end else if (enable_i) begin
            instruction_o <= instruction_fetched;
        end
    end

endmodule

`default_nettype wire

/* source/fetch_top.sv */
// Fetch stage top level: plain ports, redirect bundle, address, PC and data blocks
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               sys_reset,
    input  logic               enable_i,

    // Redirect requests
    input  logic               jump_i,
    input  fetch_pkg::addr_t   jump_target_i,
    input  logic               ctx_switch_i,
    input  fetch_pkg::addr_t   ctx_switch_target_i,
    output logic               jumping_o,

    // Instruction memory, one-cycle synchronous read
    output fetch_pkg::addr_t   instruction_address_o,
    input  fetch_pkg::instr_t  instruction_data_i,

    // To decode
    output fetch_pkg::instr_t  instruction_o,
    output fetch_pkg::addr_t   pc_o
);

    logic jumped_r;
    logic jumped_r2;

    //////////////////////////////////////////////////
    // Redirect bundle
    //////////////////////////////////////////////////

    redirect_if redir ();

    assign redir.jump              = jump_i;
    assign redir.jump_target       = jump_target_i;
    assign redir.ctx_switch        = ctx_switch_i;
    assign redir.ctx_switch_target = ctx_switch_target_i;

    //////////////////////////////////////////////////
    // Address control
    //////////////////////////////////////////////////

    iaddr_control u_iaddr_control (
        .clk                   (clk),
        .reset_n               (reset_n),
        .sys_reset             (sys_reset),
        .enable_i              (enable_i),
        .redir                 (redir.sink),
        .instruction_address_o (instruction_address_o),
        .jumping_o             (jumping_o),
        .jumped_r_o            (jumped_r),
        .jumped_r2_o           (jumped_r2)
    );

    //////////////////////////////////////////////////
    // PC control
    //////////////////////////////////////////////////

    pc_control u_pc_control (
        .clk         (clk),
        .reset_n     (reset_n),
        .sys_reset   (sys_reset),
        .enable_i    (enable_i),
        .redir       (redir.sink),
        .jumped_r_i  (jumped_r),
        .jumped_r2_i (jumped_r2),
        .pc_o        (pc_o)
    );

    //////////////////////////////////////////////////
    // Data control
    //////////////////////////////////////////////////

    instr_buffer u_instr_buffer (
        .clk                (clk),
        .reset_n            (reset_n),
        .sys_reset          (sys_reset),
        .enable_i           (enable_i),
        .instruction_data_i (instruction_data_i),
        .instruction_o      (instruction_o)
    );

endmodule

`default_nettype wire

/* tests/tb_fetch.sv */
// Fetch stage testbench with clock, reset, memory model and stimulus
// plus the reference memory image and an edge-by-edge checker
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module tb_fetch;

    localparam int HALF_PERIOD   = 50;
    localparam int BUBBLE_LIMIT  = 16;
    localparam int RANDOM_CYCLES = 600;

    logic              clk;
    logic              reset_n;
    logic              sys_reset;
    logic              enable_i;
    logic              jump_i;
    fetch_pkg::addr_t  jump_target_i;
    logic              ctx_switch_i;
    fetch_pkg::addr_t  ctx_switch_target_i;
    fetch_pkg::instr_t instruction_data_i;
    fetch_pkg::addr_t  instruction_address_o;
    logic              jumping_o;
    fetch_pkg::instr_t instruction_o;
    fetch_pkg::addr_t  pc_o;

    integer seed;

    // Inputs and outputs seen at the previous rising edge
    logic              primed;
    logic              h_en;
    logic              h_sys;
    logic              h_jump;
    logic              h_ctx;
    logic              h_jumping;
    fetch_pkg::addr_t  h_jump_target;
    fetch_pkg::addr_t  h_ctx_target;
    fetch_pkg::addr_t  h_addr;
    fetch_pkg::addr_t  h_pc;
    fetch_pkg::instr_t h_instr;

    // Enabled edges since the last redirect and the address it went to
    int                bubble;
    fetch_pkg::addr_t  redirect_addr;

    // PC of the last valid instruction
    fetch_pkg::addr_t  model_pc;

    fetch_top dut0 (
        .clk                   (clk),
        .reset_n               (reset_n),
        .sys_reset             (sys_reset),
        .enable_i              (enable_i),
        .jump_i                (jump_i),
        .jump_target_i         (jump_target_i),
        .ctx_switch_i          (ctx_switch_i),
        .ctx_switch_target_i   (ctx_switch_target_i),
        .jumping_o             (jumping_o),
        .instruction_address_o (instruction_address_o),
        .instruction_data_i    (instruction_data_i),
        .instruction_o         (instruction_o),
        .pc_o                  (pc_o)
    );

    //////////////////////////////////////////////////
    // Reference image and reporting
    //////////////////////////////////////////////////

    // Memory contents as a scramble of the whole address
    function automatic fetch_pkg::instr_t image_word(input fetch_pkg::addr_t addr);
        fetch_pkg::instr_t mixed;
        mixed = addr ^ 32'h5A3C_96E1;
        mixed = {mixed[18:0], mixed[31:19]} + (addr * 32'h0001_0DCD);
        return mixed ^ {addr[7:0], addr[31:8]};
    endfunction

    function automatic fetch_pkg::addr_t random_target();
        fetch_pkg::addr_t value;
        value = $random(seed);
        return value & 32'hFFFF_FFFC;
    endfunction

    task automatic report_failure();
        $display("Errors found");
        $fatal(1, "stopped at the first failing check");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            report_failure();
        end
    endtask

    //////////////////////////////////////////////////
    // Clock and instruction memory
    //////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    // One-cycle synchronous read of the address seen at the edge
    initial begin
        instruction_data_i = `FETCH_NOP;
        forever begin
            @(posedge clk);
            instruction_data_i <= image_word(instruction_address_o);
        end
    end

    //////////////////////////////////////////////////
    // Checker
    //////////////////////////////////////////////////

    // Judges the result of the previous edge from the inputs applied there
    task automatic check_edge();
        fetch_pkg::addr_t exp_addr;
        if (h_sys)
            exp_addr = `FETCH_START_ADDR;
        else if (h_ctx)
            exp_addr = h_ctx_target;
        else if (h_jump)
            exp_addr = h_jump_target;
        else if (h_en)
            exp_addr = h_addr + `FETCH_STEP;
        else
            exp_addr = h_addr;
        check_value("instruction_address_o", instruction_address_o, exp_addr);

        // Bubble lasts two enabled edges after the redirect
        if (h_sys || h_ctx || h_jump) begin
            bubble = 0;
            if (h_sys)
                redirect_addr = `FETCH_START_ADDR;
            else if (h_ctx)
                redirect_addr = h_ctx_target;
            else
                redirect_addr = h_jump_target;
        end else if (h_en && bubble < 2) begin
            bubble = bubble + 1;
        end
        check_value("jumping_o", {31'b0, jumping_o}, (bubble < 2) ? 32'd1 : 32'd0);

        if (h_sys) begin
            check_value("instruction_o", instruction_o, `FETCH_NOP);
        end else if (!h_en) begin
            check_value("instruction_o", instruction_o, h_instr);
            check_value("pc_o", pc_o, h_pc);
        end else if (!jumping_o) begin
            if (h_jumping)
                model_pc = redirect_addr;
            else
                model_pc = model_pc + `FETCH_STEP;
            check_value("pc_o", pc_o, model_pc);
            check_value("instruction_o", instruction_o, image_word(model_pc));
        end
    endtask

    always @(posedge clk) begin
        if (!reset_n) begin
            primed        = 1'b0;
            bubble        = 0;
            redirect_addr = `FETCH_START_ADDR;
            model_pc      = `FETCH_START_ADDR;
        end else begin
            if (primed) begin
                check_edge();
            end
            h_en          = enable_i;
            h_sys         = sys_reset;
            h_jump        = jump_i;
            h_ctx         = ctx_switch_i;
            h_jump_target = jump_target_i;
            h_ctx_target  = ctx_switch_target_i;
            h_addr        = instruction_address_o;
            h_pc          = pc_o;
            h_instr       = instruction_o;
            h_jumping     = jumping_o;
            primed        = 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    task automatic drive_idle(input logic en);
        @(negedge clk);
        enable_i     = en;
        jump_i       = 1'b0;
        ctx_switch_i = 1'b0;
        sys_reset    = 1'b0;
    endtask

    task automatic drive_redirect(input logic jmp, input fetch_pkg::addr_t jt,
                                  input logic ctx, input fetch_pkg::addr_t ct);
        @(negedge clk);
        jump_i              = jmp;
        jump_target_i       = jt;
        ctx_switch_i        = ctx;
        ctx_switch_target_i = ct;
    endtask

    task automatic wait_bubble_end();
        int waited;
        waited = 0;
        while (jumping_o && waited < BUBBLE_LIMIT) begin
            @(negedge clk);
            waited = waited + 1;
        end
        assert (!jumping_o) else begin
            $display("timeout: jumping_o stayed high for %0d cycles", BUBBLE_LIMIT);
            report_failure();
        end
    endtask

    // Consecutive words from a start address with enable held high
    task automatic follow_from(input fetch_pkg::addr_t start, input int count);
        fetch_pkg::addr_t expected_pc;
        int i;
        expected_pc = start;
        for (i = 0; i < count; i++) begin
            check_value("pc_o", pc_o, expected_pc);
            check_value("instruction_o", instruction_o, image_word(expected_pc));
            expected_pc = expected_pc + `FETCH_STEP;
            drive_idle(1'b1);
        end
    endtask

    initial begin
        fetch_pkg::addr_t jt;
        fetch_pkg::addr_t ct;
        int i;

        seed                = 56;
        reset_n             = 1'b0;
        sys_reset           = 1'b0;
        enable_i            = 1'b0;
        jump_i              = 1'b0;
        jump_target_i       = '0;
        ctx_switch_i        = 1'b0;
        ctx_switch_target_i = '0;

        // Reset state
        @(negedge clk);
        check_value("instruction_address_o", instruction_address_o, `FETCH_START_ADDR);
        check_value("jumping_o", {31'b0, jumping_o}, 32'd1);
        check_value("instruction_o", instruction_o, `FETCH_NOP);
        check_value("pc_o", pc_o, 32'd0);
        @(negedge clk);
        reset_n  = 1'b1;
        enable_i = 1'b1;

        // Sequential fetch
        drive_idle(1'b1);
        wait_bubble_end();
        follow_from(`FETCH_START_ADDR, 12);

        // Execute jump
        jt = random_target();
        drive_redirect(1'b1, jt, 1'b0, '0);
        drive_idle(1'b1);
        wait_bubble_end();
        follow_from(jt, 8);

        // Context switch beats a jump in the same cycle
        jt = random_target();
        ct = jt ^ 32'h0000_4000;
        drive_redirect(1'b1, jt, 1'b1, ct);
        drive_idle(1'b1);
        wait_bubble_end();
        follow_from(ct, 8);

        // Soft reset mid-run
        @(negedge clk);
        sys_reset = 1'b1;
        drive_idle(1'b1);
        check_value("instruction_address_o", instruction_address_o, `FETCH_START_ADDR);
        check_value("jumping_o", {31'b0, jumping_o}, 32'd1);
        check_value("instruction_o", instruction_o, `FETCH_NOP);
        wait_bubble_end();
        follow_from(`FETCH_START_ADDR, 4);

        // Random stalls and redirects checked edge by edge
        for (i = 0; i < RANDOM_CYCLES; i++) begin
            @(negedge clk);
            enable_i            = (($random(seed) & 3) != 0);
            jump_i              = (($random(seed) & 15) == 0);
            ctx_switch_i        = (($random(seed) & 31) == 0);
            jump_target_i       = random_target();
            ctx_switch_target_i = random_target();
        end
        drive_idle(1'b1);
        wait_bubble_end();
        for (i = 0; i < 4; i++) begin
            drive_idle(1'b1);
        end

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+source
source/fetch_pkg.sv
source/redirect_if.sv
source/iaddr_control.sv
source/pc_control.sv
source/instr_buffer.sv
source/fetch_top.sv
tests/tb_fetch.sv

/* Makefile */
# Verilator build and run for the fetch stage testbench

VERILATOR ?= verilator
TOP       ?= tb_fetch
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
PASS_MSG  ?= No errors

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard source/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass message shows up in the simulator output
run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
